//--- verilog/box_pkg.sv
package box_pkg;

    // Active video area
    localparam int H_ACT = 1280;
    localparam int V_ACT = 720;
    localparam int X_W   = $clog2(H_ACT);
    localparam int Y_W   = $clog2(V_ACT);

    // Box records carried in the UDP payload
    localparam int N_BOX     = 2;
    localparam int REC_BYTES = 6;
    localparam int CAPACITY  = N_BOX * REC_BYTES;
    localparam int CNT_W     = $clog2(CAPACITY + 1);

    // Border thickness in pixels
    localparam int BORDER = 2;

    // Fill indicator stretch for the LED
    localparam int FILL_HOLD = 8;
    localparam int HOLD_W    = $clog2(FILL_HOLD + 1);

    // Expanded color is 8 bits per channel
    localparam int COLOR_W = 24;

    // Record layout, most significant field first
    typedef struct packed {
        logic [X_W-1:0] start_x;
        logic [Y_W-1:0] start_y;
        logic [X_W-1:0] end_x;
        logic [Y_W-1:0] end_y;
        logic [1:0]     red;
        logic [1:0]     green;
        logic [1:0]     blue;
    } box_fields_t;

    // Same 48 bits seen as received bytes or as decoded fields
    // First byte received sits in the top byte of raw
    typedef union packed {
        logic [REC_BYTES-1:0][7:0] raw;
        box_fields_t               fields;
    } box_record_u;

endpackage : box_pkg

//--- verilog/pixel_locator.sv
module pixel_locator (
    input  logic                      clk,
    input  logic                      i_rst,
    input  logic                      i_vsync,
    input  logic                      i_de,
    input  logic [23:0]               i_rgb,
    output logic                      o_vsync,
    output logic                      o_de,
    output logic [23:0]               o_rgb,
    output logic [box_pkg::X_W-1:0]   o_x,
    output logic [box_pkg::Y_W-1:0]   o_y,
    output logic                      o_frame_start
);

    logic de_rise;
    logic de_fall;
    logic vsync_rise;

    // Previous sample is the registered copy of the stream
    assign de_rise    = i_de && !o_de;
    assign de_fall    = !i_de && o_de;
    assign vsync_rise = i_vsync && !o_vsync;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_vsync       <= 1'b0;
            o_de          <= 1'b0;
            o_frame_start <= 1'b0;
            o_x           <= '0;
            o_y           <= '0;
        end else begin
            o_vsync       <= i_vsync;
            o_de          <= i_de;
            o_frame_start <= vsync_rise;

            // Column restarts on each new line
            if (de_rise) begin
                o_x <= '0;
            end else if (i_de) begin
                o_x <= o_x + 1'b1;
            end

            // Row counts finished lines since vsync
            if (vsync_rise) begin
                o_y <= '0;
            end else if (de_fall) begin
                o_y <= o_y + 1'b1;
            end
        end
    end

    // Pixel data
    always_ff @(posedge clk) begin
        o_rgb <= i_rgb;
    end

endmodule : pixel_locator

//--- verilog/udp_reader.sv
module udp_reader (
    input  logic                                          clk,
    input  logic                                          i_rst,
    input  logic                                          i_rx_valid,
    input  logic [7:0]                                    i_rx_data,
    output logic                                          o_filled,
    output box_pkg::box_record_u [0:box_pkg::N_BOX-1]     o_records,
    output logic                                          o_udp_fill
);

    logic [box_pkg::CNT_W-1:0]  byte_cnt;
    logic [box_pkg::HOLD_W-1:0] hold_cnt;
    logic                       take_byte;
    logic                       last_byte;

    // Bytes past the buffer size are dropped
    assign take_byte = i_rx_valid && (byte_cnt < box_pkg::CNT_W'(box_pkg::CAPACITY));
    assign last_byte = i_rx_valid && (byte_cnt == box_pkg::CNT_W'(box_pkg::CAPACITY - 1));

    always_ff @(posedge clk) begin
        if (i_rst) begin
            byte_cnt <= '0;
            o_filled <= 1'b0;
        end else begin
            o_filled <= last_byte;
            if (!i_rx_valid) begin
                byte_cnt <= '0;
            end else if (take_byte) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // Byte shift through the records, record 0 ends up holding the first six bytes
    always_ff @(posedge clk) begin
        if (take_byte) begin
            for (int i = 0; i < box_pkg::N_BOX - 1; i++) begin
                o_records[i].raw <= {o_records[i].raw[box_pkg::REC_BYTES-2:0],
                                     o_records[i+1].raw[box_pkg::REC_BYTES-1]};
            end
            o_records[box_pkg::N_BOX-1].raw <=
                {o_records[box_pkg::N_BOX-1].raw[box_pkg::REC_BYTES-2:0], i_rx_data};
        end
    end

    // LED stretch, retriggered by each fill
    always_ff @(posedge clk) begin
        if (i_rst) begin
            hold_cnt <= '0;
        end else if (last_byte) begin
            hold_cnt <= box_pkg::HOLD_W'(box_pkg::FILL_HOLD);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign o_udp_fill = (hold_cnt != '0);

endmodule : udp_reader

//--- verilog/udp_parser.sv
module udp_parser (
    input  logic                                            clk,
    input  logic                                            i_rst,
    input  logic                                            i_filled,
    input  box_pkg::box_record_u [0:box_pkg::N_BOX-1]       i_records,
    input  logic                                            i_frame_start,
    output logic [box_pkg::N_BOX*box_pkg::X_W-1:0]          o_start_xs,
    output logic [box_pkg::N_BOX*box_pkg::Y_W-1:0]          o_start_ys,
    output logic [box_pkg::N_BOX*box_pkg::X_W-1:0]          o_end_xs,
    output logic [box_pkg::N_BOX*box_pkg::Y_W-1:0]          o_end_ys,
    output logic [box_pkg::N_BOX*box_pkg::COLOR_W-1:0]      o_colors
);

    logic [box_pkg::N_BOX*box_pkg::X_W-1:0]     dec_start_xs, pend_start_xs;
    logic [box_pkg::N_BOX*box_pkg::Y_W-1:0]     dec_start_ys, pend_start_ys;
    logic [box_pkg::N_BOX*box_pkg::X_W-1:0]     dec_end_xs, pend_end_xs;
    logic [box_pkg::N_BOX*box_pkg::Y_W-1:0]     dec_end_ys, pend_end_ys;
    logic [box_pkg::N_BOX*box_pkg::COLOR_W-1:0] dec_colors, pend_colors;

    // Decode each record, 2-bit channels repeated up to 8 bits
    always_comb begin
        for (int i = 0; i < box_pkg::N_BOX; i++) begin
            dec_start_xs[i*box_pkg::X_W +: box_pkg::X_W] = i_records[i].fields.start_x;
            dec_start_ys[i*box_pkg::Y_W +: box_pkg::Y_W] = i_records[i].fields.start_y;
            dec_end_xs[i*box_pkg::X_W +: box_pkg::X_W]   = i_records[i].fields.end_x;
            dec_end_ys[i*box_pkg::Y_W +: box_pkg::Y_W]   = i_records[i].fields.end_y;
            dec_colors[i*box_pkg::COLOR_W +: box_pkg::COLOR_W] =
                {{4{i_records[i].fields.red}},
                 {4{i_records[i].fields.green}},
                 {4{i_records[i].fields.blue}}};
        end
    end

    // Pending set loads on fill, active set swaps in at frame start
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pend_start_xs <= '0;
            pend_start_ys <= '0;
            pend_end_xs   <= '0;
            pend_end_ys   <= '0;
            pend_colors   <= '0;
            o_start_xs    <= '0;
            o_start_ys    <= '0;
            o_end_xs      <= '0;
            o_end_ys      <= '0;
            o_colors      <= '0;
        end else begin
            if (i_filled) begin
                pend_start_xs <= dec_start_xs;
                pend_start_ys <= dec_start_ys;
                pend_end_xs   <= dec_end_xs;
                pend_end_ys   <= dec_end_ys;
                pend_colors   <= dec_colors;
            end
            if (i_frame_start) begin
                o_start_xs <= pend_start_xs;
                o_start_ys <= pend_start_ys;
                o_end_xs   <= pend_end_xs;
                o_end_ys   <= pend_end_ys;
                o_colors   <= pend_colors;
            end
        end
    end

endmodule : udp_parser

//--- verilog/box_overlay.sv
module box_overlay (
    input  logic                                        clk,
    input  logic                                        i_rst,
    input  logic                                        i_vsync,
    input  logic                                        i_de,
    input  logic [23:0]                                 i_rgb,
    input  logic [box_pkg::X_W-1:0]                     i_x,
    input  logic [box_pkg::Y_W-1:0]                     i_y,
    input  logic [box_pkg::N_BOX*box_pkg::X_W-1:0]      i_start_xs,
    input  logic [box_pkg::N_BOX*box_pkg::Y_W-1:0]      i_start_ys,
    input  logic [box_pkg::N_BOX*box_pkg::X_W-1:0]      i_end_xs,
    input  logic [box_pkg::N_BOX*box_pkg::Y_W-1:0]      i_end_ys,
    input  logic [box_pkg::N_BOX*box_pkg::COLOR_W-1:0]  i_colors,
    output logic                                        o_vsync,
    output logic                                        o_de,
    output logic [23:0]                                 o_rgb
);

    logic [box_pkg::X_W-1:0] sx;
    logic [box_pkg::X_W-1:0] ex;
    logic [box_pkg::Y_W-1:0] sy;
    logic [box_pkg::Y_W-1:0] ey;
    logic                    in_x;
    logic                    in_y;
    logic                    near_edge;
    logic [23:0]             pix_rgb;

    // Walk boxes from the top index down so box 0 has the final say
    always_comb begin
        pix_rgb   = i_rgb;
        sx        = '0;
        ex        = '0;
        sy        = '0;
        ey        = '0;
        in_x      = 1'b0;
        in_y      = 1'b0;
        near_edge = 1'b0;
        for (int i = box_pkg::N_BOX - 1; i >= 0; i--) begin
            sx = i_start_xs[i*box_pkg::X_W +: box_pkg::X_W];
            ex = i_end_xs[i*box_pkg::X_W +: box_pkg::X_W];
            sy = i_start_ys[i*box_pkg::Y_W +: box_pkg::Y_W];
            ey = i_end_ys[i*box_pkg::Y_W +: box_pkg::Y_W];

            // An inverted box never passes both range checks
            in_x = (i_x >= sx) && (i_x <= ex);
            in_y = (i_y >= sy) && (i_y <= ey);

            // Distances are only meaningful inside the box
            near_edge = ((i_x - sx) < box_pkg::X_W'(box_pkg::BORDER)) ||
                        ((ex - i_x) < box_pkg::X_W'(box_pkg::BORDER)) ||
                        ((i_y - sy) < box_pkg::Y_W'(box_pkg::BORDER)) ||
                        ((ey - i_y) < box_pkg::Y_W'(box_pkg::BORDER));

            if (i_de && in_x && in_y && near_edge) begin
                pix_rgb = i_colors[i*box_pkg::COLOR_W +: box_pkg::COLOR_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_vsync <= 1'b0;
            o_de    <= 1'b0;
        end else begin
            o_vsync <= i_vsync;
            o_de    <= i_de;
        end
    end

    always_ff @(posedge clk) begin
        o_rgb <= pix_rgb;
    end

endmodule : box_overlay

//--- verilog/box_overlay_top.sv
module box_overlay_top (
    input  logic        clk,
    input  logic        i_rst,
    input  logic        i_rx_valid,
    input  logic [7:0]  i_rx_data,
    input  logic        i_vsync,
    input  logic        i_de,
    input  logic [23:0] i_rgb,
    output logic        o_vsync,
    output logic        o_de,
    output logic [23:0] o_rgb,
    output logic        o_udp_fill
);

    // Receive path
    logic                                        filled;
    box_pkg::box_record_u [0:box_pkg::N_BOX-1]   records;
    logic [box_pkg::N_BOX*box_pkg::X_W-1:0]      box_start_xs;
    logic [box_pkg::N_BOX*box_pkg::Y_W-1:0]      box_start_ys;
    logic [box_pkg::N_BOX*box_pkg::X_W-1:0]      box_end_xs;
    logic [box_pkg::N_BOX*box_pkg::Y_W-1:0]      box_end_ys;
    logic [box_pkg::N_BOX*box_pkg::COLOR_W-1:0]  box_colors;

    // Pixel path
    logic                    pix_vsync;
    logic                    pix_de;
    logic [23:0]             pix_rgb;
    logic [box_pkg::X_W-1:0] pix_x;
    logic [box_pkg::Y_W-1:0] pix_y;
    logic                    frame_start;

    udp_reader u_udp_reader (
        .clk       (clk       ),
        .i_rst     (i_rst     ),
        .i_rx_valid(i_rx_valid),
        .i_rx_data (i_rx_data ),
        .o_filled  (filled    ),
        .o_records (records   ),
        .o_udp_fill(o_udp_fill)
    );

    udp_parser u_udp_parser (
        .clk          (clk         ),
        .i_rst        (i_rst       ),
        .i_filled     (filled      ),
        .i_records    (records     ),
        .i_frame_start(frame_start ),
        .o_start_xs   (box_start_xs),
        .o_start_ys   (box_start_ys),
        .o_end_xs     (box_end_xs  ),
        .o_end_ys     (box_end_ys  ),
        .o_colors     (box_colors  )
    );

    pixel_locator u_pixel_locator (
        .clk          (clk        ),
        .i_rst        (i_rst      ),
        .i_vsync      (i_vsync    ),
        .i_de         (i_de       ),
        .i_rgb        (i_rgb      ),
        .o_vsync      (pix_vsync  ),
        .o_de         (pix_de     ),
        .o_rgb        (pix_rgb    ),
        .o_x          (pix_x      ),
        .o_y          (pix_y      ),
        .o_frame_start(frame_start)
    );

    box_overlay u_box_overlay (
        .clk       (clk         ),
        .i_rst     (i_rst       ),
        .i_vsync   (pix_vsync   ),
        .i_de      (pix_de      ),
        .i_rgb     (pix_rgb     ),
        .i_x       (pix_x       ),
        .i_y       (pix_y       ),
        .i_start_xs(box_start_xs),
        .i_start_ys(box_start_ys),
        .i_end_xs  (box_end_xs  ),
        .i_end_ys  (box_end_ys  ),
        .i_colors  (box_colors  ),
        .o_vsync   (o_vsync     ),
        .o_de      (o_de        ),
        .o_rgb     (o_rgb       )
    );

endmodule : box_overlay_top

//--- bench/box_overlay_tb.sv
module box_overlay_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_TESTS = 7;
    localparam int REC_WORDS = 22;
    localparam int BW        = box_pkg::BORDER;

    logic        clk = 1'b0;
    logic        i_rst;
    logic        i_rx_valid;
    logic [7:0]  i_rx_data;
    logic        i_vsync;
    logic        i_de;
    logic [23:0] i_rgb;
    logic        o_vsync;
    logic        o_de;
    logic [23:0] o_rgb;
    logic        o_udp_fill;

    logic [31:0] pat_mem [0:MAX_TESTS*REC_WORDS];
    logic [8:0]  rx_q [$];
    integer      seed = 32'h780a_8b15;

    // Box model as start x, start y, end x, end y and expanded color
    int          pend_box [box_pkg::N_BOX][5];
    int          act_box [box_pkg::N_BOX][5];

    // In-flight pixels {check, vsync, de, rgb}
    logic [26:0] pipe [0:1];
    int          pipe_x [0:1];
    int          pipe_y [0:1];

    int          test_errors = 0;
    int          pass_tests = 0;
    int          fail_tests = 0;
    int          fill_rises = 0;
    logic        fill_prev = 1'b0;

    box_overlay_top i_box_overlay_top (.*);

    always #5 clk = ~clk;

    // Lowest index box whose border covers the pixel or -1 if none
    function automatic int border_owner(input int x, input int y);
        for (int i = 0; i < box_pkg::N_BOX; i++) begin
            if (x >= act_box[i][0] && x <= act_box[i][2] &&
                y >= act_box[i][1] && y <= act_box[i][3] &&
                (x - act_box[i][0] < BW || act_box[i][2] - x < BW ||
                 y - act_box[i][1] < BW || act_box[i][3] - y < BW)) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic [23:0] next_pixel(input logic [31:0] fill);
        logic [31:0] r;
        if (fill[31]) begin
            r = $random(seed);
            return r[23:0];
        end
        return fill[23:0];
    endfunction

    // Queue one payload run and refresh the pending model after a full one
    task automatic queue_payload(input int base);
        int          len;
        logic [47:0] rec;
        len = pat_mem[base + 1];
        for (int k = 0; k < len; k++) begin
            rx_q.push_back({1'b1, pat_mem[base + 2 + k][7:0]});
        end
        rx_q.push_back(9'h000);
        if (len >= box_pkg::CAPACITY) begin
            for (int i = 0; i < box_pkg::N_BOX; i++) begin
                rec = '0;
                for (int k = 0; k < 6; k++) begin
                    rec = {rec[39:0], pat_mem[base + 2 + 6 * i + k][7:0]};
                end
                pend_box[i][0] = int'(rec[47:37]);
                pend_box[i][1] = int'(rec[36:27]);
                pend_box[i][2] = int'(rec[26:16]);
                pend_box[i][3] = int'(rec[15:6]);
                // Channel level 0 to 3 scaled by 0x55 spans 0x00 to 0xff
                pend_box[i][4] = ((int'(rec[5:4]) * 'h55) << 16) |
                                 ((int'(rec[3:2]) * 'h55) << 8) |
                                 (int'(rec[1:0]) * 'h55);
            end
        end
    endtask

    // Check the pixel driven two clocks back and drive the next one
    task automatic step(input logic vs, input logic de, input logic [23:0] rgb,
                        input int x, input int y);
        int          owner;
        logic [8:0]  ent;
        logic [23:0] exp_rgb;
        @(posedge clk);
        #1;
        if (o_udp_fill && !fill_prev) begin
            fill_rises++;
        end
        fill_prev = o_udp_fill;
        if (pipe[1][26]) begin
            if ({o_vsync, o_de} !== pipe[1][25:24]) begin
                $display("** Error at %0t: x=%0d y=%0d vsync/de expected %b got %b",
                         $time, pipe_x[1], pipe_y[1], pipe[1][25:24], {o_vsync, o_de});
                test_errors++;
            end else if (o_de && o_rgb !== pipe[1][23:0]) begin
                $display("** Error at %0t: x=%0d y=%0d expected %06h got %06h",
                         $time, pipe_x[1], pipe_y[1], pipe[1][23:0], o_rgb);
                test_errors++;
            end
        end
        pipe[1]   = pipe[0];
        pipe_x[1] = pipe_x[0];
        pipe_y[1] = pipe_y[0];
        ent = 9'h000;
        if (rx_q.size() > 0) begin
            ent = rx_q.pop_front();
        end
        owner   = de ? border_owner(x, y) : -1;
        exp_rgb = rgb;
        if (owner >= 0) begin
            exp_rgb = act_box[owner][4][23:0];
        end
        pipe[0]    = {1'b1, vs, de, exp_rgb};
        pipe_x[0]  = x;
        pipe_y[0]  = y;
        i_rx_valid = ent[8];
        i_rx_data  = ent[7:0];
        i_vsync    = vs;
        i_de       = de;
        i_rgb      = rgb;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step(1'b0, 1'b0, 24'h0, 0, 0);
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        test_errors++;
    endtask

    task automatic check_fill(input int base, input int rises_before);
        int n;
        for (n = 0; n < 64 && rx_q.size() > 0; n++) begin
            idle_cycles(1);
        end
        if (rx_q.size() > 0) report_timeout("the payload to be sent");
        if (pat_mem[base + 1] >= box_pkg::CAPACITY) begin
            for (n = 0; n < 32 && fill_rises == rises_before; n++) begin
                idle_cycles(1);
            end
            if (fill_rises == rises_before) report_timeout("o_udp_fill to rise");
            for (n = 0; n < box_pkg::FILL_HOLD + 16 && o_udp_fill; n++) begin
                idle_cycles(1);
            end
            if (o_udp_fill) report_timeout("o_udp_fill to fall");
        end else begin
            idle_cycles(2 * box_pkg::FILL_HOLD);
            if (fill_rises != rises_before) begin
                $display("** Error at %0t: o_udp_fill rose after a short payload", $time);
                test_errors++;
            end
        end
    endtask

    // Vsync pulse and then w x h pixels with a short blank after each line
    task automatic run_frame(input int base, input bit mid_payload, input bit count_it);
        int border_cnt;
        border_cnt = 0;
        act_box = pend_box;
        repeat (2) step(1'b1, 1'b0, 24'h0, 0, 0);
        idle_cycles(4);
        if (mid_payload) queue_payload(base);
        for (int y = 0; y < int'(pat_mem[base + 19]); y++) begin
            for (int x = 0; x < int'(pat_mem[base + 18]); x++) begin
                if (border_owner(x, y) >= 0) border_cnt++;
                step(1'b0, 1'b1, next_pixel(pat_mem[base + 20]), x, y);
            end
            idle_cycles(3);
        end
        if (count_it && border_cnt != int'(pat_mem[base + 21])) begin
            $display("** Error at %0t: border pixel count expected %0d got %0d",
                     $time, pat_mem[base + 21], border_cnt);
            test_errors++;
        end
    endtask

    initial begin
        int num_tests;
        int base;
        int rises;
        i_rst      = 1'b1;
        i_rx_valid = 1'b0;
        i_rx_data  = 8'h00;
        i_vsync    = 1'b0;
        i_de       = 1'b0;
        i_rgb      = 24'h0;
        pipe[0]    = '0;
        pipe[1]    = '0;
        $readmemh("bench/box_overlay_patterns.txt", pat_mem);
        num_tests = pat_mem[0];
        repeat (5) @(posedge clk);
        #1;
        i_rst = 1'b0;
        if (num_tests < 1 || num_tests > MAX_TESTS) begin
            $display("Pattern file is missing or holds a bad test count");
            fail_tests++;
            num_tests = 0;
        end
        for (int t = 0; t < num_tests; t++) begin
            base        = 1 + t * REC_WORDS;
            test_errors = 0;
            rises       = fill_rises;
            case (pat_mem[base])
                0: begin
                    queue_payload(base);
                    check_fill(base, rises);
                    run_frame(base, 1'b0, 1'b1);
                end
                1: begin
                    // Payload lands while the old boxes are still on screen
                    run_frame(base, 1'b1, 1'b0);
                    if (fill_rises == rises) begin
                        $display("** Error at %0t: no o_udp_fill for mid-frame payload", $time);
                        test_errors++;
                    end
                    run_frame(base, 1'b0, 1'b1);
                end
                default: run_frame(base, 1'b0, 1'b1);
            endcase
            if (test_errors == 0) begin
                pass_tests++;
                $display("Test %0d mode %0d: passed", t + 1, pat_mem[base]);
            end else begin
                fail_tests++;
                $display("Test %0d mode %0d: failed with %0d errors", t + 1, pat_mem[base],
                         test_errors);
            end
        end
        $display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
        if (fail_tests == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : box_overlay_tb

//--- bench/box_overlay_patterns.txt
// Per test: mode (0 payload then frame, 1 payload mid-frame, 2 no payload), payload length,
// 16 payload bytes, line length, line count, fill (bit 31 random) and border pixel count
07
// Reset boxes, black dot at (0,0)
02 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
10 0C 80000000 01
// Two separated boxes, red (1,1)-(6,5) and green (9,3)-(14,9)
00 0C
00 20 08 06 01 70 01 20 18 0E 02 4C 00 00 00 00
10 0C 80000000 40
// Overlap, blue (2,2)-(9,7) over mixed color (6,4)-(13,10)
00 0C
00 40 10 09 01 C3 00 C0 20 0D 02 A7 00 00 00 00
10 0C 80000000 4C
// Red box and an inverted white box (8,1)-(3,6)
00 0C
00 20 08 06 01 70 01 00 08 03 01 BF 00 00 00 00
10 0C 00808080 1C
// Short payload keeps the previous boxes
00 07
00 40 10 09 01 C3 00 00 00 00 00 00 00 00 00 00
10 0C 80000000 1C
// Long payload, trailing bytes dropped
00 0E
00 20 08 06 01 70 01 20 18 0E 02 4C FF FF 00 00
10 0C 80000000 40
// Payload during a frame shows from the next vsync
01 0C
00 40 10 09 01 C3 00 C0 20 0D 02 A7 00 00 00 00
10 0C 80000000 4C

//--- box_overlay_top.f
verilog/box_pkg.sv
verilog/pixel_locator.sv
verilog/udp_reader.sv
verilog/udp_parser.sv
verilog/box_overlay.sv
verilog/box_overlay_top.sv
bench/box_overlay_tb.sv

//--- Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --timescale 1ns/1ps -j 0
TOP       = box_overlay_tb
FILELIST  = box_overlay_top.f
BUILD_DIR = obj_dir
PASS_MSG  = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
